//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [31:0] addr_t;   // bus address
    typedef logic [31:0] word_t;   // bus data
    typedef logic [3:0]  be_t;     // byte-lane enables
    typedef logic [7:0]  byte_t;   // serial byte
    typedef logic [15:0] baud_t;   // clocks per serial bit

    typedef struct packed {
        logic  wr;      // 1 = write, 0 = read
        addr_t addr;
        word_t wdata;
        be_t   be;      // lane 0 is mandatory
    } bus_req_t;

    // register map
    localparam addr_t UART_BAUD_L_ADDR      = 32'h0000_0000;
    localparam addr_t UART_BAUD_H_ADDR      = 32'h0000_0004;
    localparam addr_t UART_STATUS_ADDR      = 32'h0000_0008;
    localparam addr_t UART_DATA_ADDR        = 32'h0000_000C;
    localparam addr_t UART_INT_ADDR         = 32'h0000_0010;
    localparam addr_t UART_INT_PENDING_ADDR = 32'h0000_0014;

    // bit positions in the enable and pending registers
    localparam int UART_INT_RX_READY = 0;
    localparam int UART_INT_TX_EMPTY = 1;

    // transmit FIFO geometry, depth must be 2**TX_PTR_W
    localparam int TX_FIFO_DEPTH = 4;
    localparam int TX_PTR_W      = 2;

endpackage

`default_nettype wire

//--- uart_tx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_fifo import uart_pkg::*; (
    input  wire   clk,
    input  wire   rst_n,
    input  wire   i_push,
    input  byte_t i_data,
    output logic  o_valid,
    output byte_t o_data,
    input  wire   i_ready,
    output logic  o_full,
    output logic  o_empty
);

    byte_t               mem [TX_FIFO_DEPTH];
    logic [TX_PTR_W-1:0] wr_ptr;
    logic [TX_PTR_W-1:0] rd_ptr;
    logic [TX_PTR_W:0]   count;    // one extra bit to tell full from empty
    logic                do_push;
    logic                do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == (TX_PTR_W+1)'(TX_FIFO_DEPTH));
    assign o_valid = !o_empty;
    assign o_data  = mem[rd_ptr];

    assign do_push = i_push && !o_full;    // push into a full FIFO is lost
    assign do_pop  = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (TX_PTR_W+1)'(do_push) - (TX_PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= i_data;
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire   clk,
    input  wire   rst_n,
    input  baud_t i_baud_div,
    input  wire   i_valid,
    input  byte_t i_data,
    output logic  o_ready,
    output logic  o_tx
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

    tx_state_t  state;
    baud_t      baud_cnt;
    logic [2:0] bit_cnt;
    byte_t      shreg;
    logic       bit_done;

    // a divisor of 0 degrades to one clock per bit
    assign bit_done = ({1'b0, baud_cnt} + 17'd1) >= {1'b0, i_baud_div};
    assign o_ready  = (state == IDLE);

    always_comb begin
        case (state)
            START:   o_tx = 1'b0;
            DATA:    o_tx = shreg[0];    // lsb first
            default: o_tx = 1'b1;        // idle and stop are mark level
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (state == IDLE) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (i_valid) state <= START;
        end else begin
            baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
            if (bit_done) begin
                case (state)
                    START:   state <= DATA;
                    DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= STOP;
                    end
                    default: state <= IDLE;   // end of stop bit
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && i_valid)        shreg <= i_data;
        else if (state == DATA && bit_done) shreg <= shreg >> 1;
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire   clk,
    input  wire   rst_n,
    input  baud_t i_baud_div,
    input  wire   i_rx,
    input  wire   i_read,
    output logic  o_ready,
    output byte_t o_byte
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    baud_t      baud_cnt;
    logic [2:0] bit_cnt;
    byte_t      shreg;
    logic       bit_done;
    logic       half_done;

    assign bit_done  = ({1'b0, baud_cnt} + 17'd1) >= {1'b0, i_baud_div};
    assign half_done = ({1'b0, baud_cnt} + 17'd1) >= {2'b0, i_baud_div[15:1]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;    // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            o_ready  <= 1'b0;
            o_byte   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!rx_sync) state <= START;   // falling edge seen
                end
                START: begin
                    baud_cnt <= half_done ? '0 : baud_cnt + 1'b1;
                    if (half_done) state <= rx_sync ? IDLE : DATA;  // glitch rejected
                end
                DATA: begin
                    baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= STOP;
                    end
                end
                default: begin
                    baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
                    if (bit_done) state <= IDLE;
                end
            endcase

            // new byte wins over a read in the same cycle
            if (state == STOP && bit_done && rx_sync) begin
                o_ready <= 1'b1;
                o_byte  <= shreg;   // overwrites an unread byte
            end else if (i_read) begin
                o_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && bit_done) shreg <= {rx_sync, shreg[7:1]};
    end

endmodule

`default_nettype wire

//--- uart.sv
`timescale 1ns/100ps
`default_nettype none

module uart import uart_pkg::*; (
    input  wire   clk,
    input  wire   rst_n,
    input  baud_t i_baud_div,
    input  wire   i_tx_push,
    input  byte_t i_tx_data,
    output logic  o_tx_full,
    output logic  o_tx_empty,
    output logic  o_tx,
    input  wire   i_rx,
    input  wire   i_rx_read,
    output logic  o_rx_ready,
    output byte_t o_rx_byte
);

    logic  fifo_valid;
    byte_t fifo_data;
    logic  fifo_empty;
    logic  tx_ready;

    // empty means the last stop bit has left, not just the FIFO drained
    assign o_tx_empty = fifo_empty && tx_ready;

    uart_tx_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_push  (i_tx_push),
        .i_data  (i_tx_data),
        .o_valid (fifo_valid),
        .o_data  (fifo_data),
        .i_ready (tx_ready),
        .o_full  (o_tx_full),
        .o_empty (fifo_empty)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_baud_div (i_baud_div),
        .i_valid    (fifo_valid),
        .i_data     (fifo_data),
        .o_ready    (tx_ready),
        .o_tx       (o_tx)
    );

    uart_rx u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_baud_div (i_baud_div),
        .i_rx       (i_rx),
        .i_read     (i_rx_read),
        .o_ready    (o_rx_ready),
        .o_byte     (o_rx_byte)
    );

endmodule

`default_nettype wire

//--- uart_mem.sv
`timescale 1ns/100ps
`default_nettype none

module uart_mem import uart_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  wire      i_enable,   // must drop between commands
    input  bus_req_t i_req,
    output logic     o_ready,
    output word_t    o_rdata,
    output logic     o_irq,
    output logic     o_bus_err,
    input  wire      i_rx,
    output logic     o_tx
);

    typedef enum logic {ISSUE, RETIRE} mem_state_t;

    mem_state_t state;
    baud_t      baud_div;
    logic       tx_push;
    byte_t      tx_data;
    logic       rx_read;
    logic       tx_full;
    logic       tx_empty;
    logic       rx_ready;
    byte_t      rx_byte;
    logic       tx_empty_q;
    logic       rx_ready_q;
    logic [1:0] int_en;
    logic [1:0] int_pend;
    logic [1:0] pend_set;
    logic [1:0] pend_clr;
    logic       delay;     // extra cycle for a DATA read
    logic       accept;
    logic       addr_ok;

    uart u_uart (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_baud_div (baud_div),
        .i_tx_push  (tx_push),
        .i_tx_data  (tx_data),
        .o_tx_full  (tx_full),
        .o_tx_empty (tx_empty),
        .o_tx       (o_tx),
        .i_rx       (i_rx),
        .i_rx_read  (rx_read),
        .o_rx_ready (rx_ready),
        .o_rx_byte  (rx_byte)
    );

    assign o_irq  = |(int_en & int_pend);
    assign accept = i_enable && !o_ready && (state == ISSUE);  // error implies ready

    always_comb begin
        case (i_req.addr)
            UART_BAUD_L_ADDR, UART_BAUD_H_ADDR, UART_STATUS_ADDR,
            UART_DATA_ADDR, UART_INT_ADDR, UART_INT_PENDING_ADDR: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    // interrupts latch on rising edges only
    always_comb begin
        pend_set = '0;
        pend_set[UART_INT_RX_READY] = rx_ready && !rx_ready_q;
        pend_set[UART_INT_TX_EMPTY] = tx_empty && !tx_empty_q;
        pend_clr = '0;
        if (accept && i_req.wr && i_req.be[0] && i_req.addr == UART_INT_PENDING_ADDR)
            pend_clr = i_req.wdata[1:0];   // write one to clear
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ISSUE;
            baud_div   <= '0;
            tx_push    <= 1'b0;
            rx_read    <= 1'b0;
            delay      <= 1'b0;
            tx_empty_q <= 1'b1;   // FIFO starts empty, no edge out of reset
            rx_ready_q <= 1'b0;
            int_en     <= '0;
            int_pend   <= '0;
            o_ready    <= 1'b0;
            o_bus_err  <= 1'b0;
            o_rdata    <= '0;
        end else begin
            tx_empty_q <= tx_empty;
            rx_ready_q <= rx_ready;
            int_pend   <= (int_pend & ~pend_clr) | pend_set;   // a new edge wins

            if (!i_enable) begin
                // master released, get ready for the next command
                o_ready   <= 1'b0;
                o_bus_err <= 1'b0;
                state     <= ISSUE;
                tx_push   <= 1'b0;
                rx_read   <= 1'b0;
                delay     <= 1'b0;
            end else if (accept) begin
                if (!i_req.be[0] || !addr_ok) begin
                    o_bus_err <= 1'b1;   // answer at once with an error
                    o_ready   <= 1'b1;
                    o_rdata   <= '0;
                end else if (i_req.wr) begin
                    state   <= RETIRE;
                    o_rdata <= '0;
                    case (i_req.addr)
                        UART_BAUD_L_ADDR: begin
                            if (i_req.be[1]) baud_div       <= i_req.wdata[15:0];
                            else             baud_div[7:0]  <= i_req.wdata[7:0];
                        end
                        UART_BAUD_H_ADDR: baud_div[15:8] <= i_req.wdata[7:0];
                        UART_DATA_ADDR: begin
                            if (!tx_full) begin   // silently dropped when full
                                tx_data <= i_req.wdata[7:0];
                                tx_push <= 1'b1;
                            end
                        end
                        UART_INT_ADDR: int_en <= i_req.wdata[1:0];
                        default: ;                // status is read only, pending done above
                    endcase
                end else begin
                    state <= RETIRE;
                    case (i_req.addr)
                        UART_BAUD_L_ADDR: o_rdata <= i_req.be[1] ? {16'b0, baud_div}
                                                                  : {24'b0, baud_div[7:0]};
                        UART_BAUD_H_ADDR: o_rdata <= {24'b0, baud_div[15:8]};
                        UART_STATUS_ADDR: o_rdata <= {30'b0, tx_full, rx_ready};
                        UART_DATA_ADDR: begin
                            if (rx_ready) begin
                                rx_read <= 1'b1;   // consume the held byte
                                delay   <= 1'b1;
                            end
                        end
                        UART_INT_ADDR: o_rdata <= {30'b0, int_en};
                        default:       o_rdata <= {30'b0, int_pend};
                    endcase
                end
            end else if (state == RETIRE && !o_ready) begin
                tx_push <= 1'b0;
                rx_read <= 1'b0;
                if (delay) begin
                    delay <= 1'b0;   // receiver settles
                end else begin
                    if (!i_req.wr && i_req.addr == UART_DATA_ADDR)
                        o_rdata <= {24'b0, rx_byte};
                    o_ready <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;           // released like any other input
    end

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker import uart_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        i_enable,
    input  bus_req_t   i_req,
    input  wire        i_ready,
    input  word_t      i_rdata,
    input  wire        i_irq,
    input  wire        i_bus_err,
    input  word_t      i_dyn_mask,    // bits of STATUS / INT_PENDING worth checking
    input  word_t      i_dyn_exp,
    input  wire        i_pend_known,
    input  wire  [1:0] i_pend_exp,
    input  wire        i_expect_full, // a DATA write now is dropped
    output int         o_errors
);

    baud_t      baud;
    logic [1:0] int_en;
    byte_t      sent[$];    // bytes on their way through the loopback
    logic       ready_q;

    task automatic check_response();
        logic  valid_addr;
        logic  exp_err;
        logic  exp_irq;
        word_t exp;
        word_t mask;
        valid_addr = i_req.addr inside {UART_BAUD_L_ADDR, UART_BAUD_H_ADDR, UART_STATUS_ADDR,
                                        UART_DATA_ADDR, UART_INT_ADDR, UART_INT_PENDING_ADDR};
        exp_err = !i_req.be[0] || !valid_addr;
        exp     = '0;
        mask    = '1;
        if (!exp_err && i_req.wr) begin
            case (i_req.addr)
                UART_BAUD_L_ADDR: begin
                    if (i_req.be[1]) baud = i_req.wdata[15:0];
                    else             baud[7:0] = i_req.wdata[7:0];
                end
                UART_BAUD_H_ADDR: baud[15:8] = i_req.wdata[7:0];
                UART_DATA_ADDR: begin
                    if (!i_expect_full) sent.push_back(i_req.wdata[7:0]);
                end
                UART_INT_ADDR:    int_en = i_req.wdata[1:0];
                default: ;
            endcase
        end else if (!exp_err) begin
            case (i_req.addr)
                UART_BAUD_L_ADDR: exp = i_req.be[1] ? {16'b0, baud} : {24'b0, baud[7:0]};
                UART_BAUD_H_ADDR: exp = {24'b0, baud[15:8]};
                UART_DATA_ADDR: begin
                    if (sent.size() > 0) begin
                        exp = {24'b0, sent.pop_front()};   // oldest byte first
                    end else begin
                        $display("DATA read while no byte was sent");
                        o_errors++;
                    end
                end
                UART_INT_ADDR:    exp = {30'b0, int_en};
                default: begin
                    exp  = i_dyn_exp;
                    mask = i_dyn_mask;
                end
            endcase
        end
        if (i_bus_err !== exp_err) begin
            $display("Error: o_bus_err expected 0x%0h got 0x%0h (addr 0x%08h)",
                     exp_err, i_bus_err, i_req.addr);
            o_errors++;
        end
        if (((i_rdata ^ exp) & mask) != '0) begin
            $display("Error: o_rdata expected 0x%08h got 0x%08h (addr 0x%08h mask 0x%08h)",
                     exp, i_rdata, i_req.addr, mask);
            o_errors++;
        end
        if (int_en == 2'b00 || i_pend_known) begin
            exp_irq = |(int_en & i_pend_exp) && int_en != 2'b00;
            if (i_irq !== exp_irq) begin
                $display("Error: o_irq expected 0x%0h got 0x%0h", exp_irq, i_irq);
                o_errors++;
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            baud     = '0;
            int_en   = '0;
            ready_q  = 1'b0;
            o_errors = 0;
            sent.delete();
        end else begin
            if (i_ready && !ready_q && i_enable) check_response();
            ready_q = i_ready;
        end
    end

endmodule

`default_nettype wire

//--- uart_mem_assert.sv
`timescale 1ns/100ps
`default_nettype none

module uart_mem_assert (
    input wire       clk,
    input wire       rst_n,
    input wire       i_enable,
    input wire       o_ready,
    input wire       o_bus_err,
    input wire       o_irq,
    input wire [1:0] int_en
);

    assert property (@(posedge clk) disable iff (!rst_n) o_bus_err |-> o_ready)
        else $error("o_bus_err high without o_ready");

    // ready holds until the master lets go
    assert property (@(posedge clk) disable iff (!rst_n) $fell(o_ready) |-> $past(!i_enable))
        else $error("o_ready fell while i_enable was still high");

    assert property (@(posedge clk) disable iff (!rst_n) (int_en == 2'b00) |-> !o_irq)
        else $error("o_irq high with all interrupts disabled");

endmodule

bind uart_mem uart_mem_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_enable  (i_enable),
    .o_ready   (o_ready),
    .o_bus_err (o_bus_err),
    .o_irq     (o_irq),
    .int_en    (int_en)
);

`default_nettype wire

//--- tb_uart.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart import uart_pkg::*; ;

    localparam int MAX_CMDS  = 400;   // all bus commands, polls included
    localparam int MAX_BYTES = 20;
    localparam int TEST_DIV  = 8;
    localparam int WATCHDOG  = 2 * (MAX_CMDS * 10 + MAX_BYTES * 12 * TEST_DIV);

    logic       clk;
    logic       rst_n;
    logic       enable;
    bus_req_t   req;
    logic       ready;
    word_t      rdata;
    logic       irq;
    logic       bus_err;
    logic       serial;       // loopback line
    word_t      dyn_mask;
    word_t      dyn_exp;
    logic       pend_known;
    logic [1:0] pend_exp;
    logic       expect_full;
    int         chk_errors;
    int         local_errors;
    int         test_start;
    int         tests_run;
    int         tests_failed;
    word_t      last_rdata;
    word_t      div;

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    uart_mem u_uart_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (enable),
        .i_req     (req),
        .o_ready   (ready),
        .o_rdata   (rdata),
        .o_irq     (irq),
        .o_bus_err (bus_err),
        .i_rx      (serial),
        .o_tx      (serial)
    );

    tb_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_enable      (enable),
        .i_req         (req),
        .i_ready       (ready),
        .i_rdata       (rdata),
        .i_irq         (irq),
        .i_bus_err     (bus_err),
        .i_dyn_mask    (dyn_mask),
        .i_dyn_exp     (dyn_exp),
        .i_pend_known  (pend_known),
        .i_pend_exp    (pend_exp),
        .i_expect_full (expect_full),
        .o_errors      (chk_errors)
    );

    task automatic bus_cmd(input logic wr, input addr_t addr, input word_t wdata, input be_t be);
        int n;
        n = 0;
        @(posedge clk);
        #2;
        req.wr    = wr;
        req.addr  = addr;
        req.wdata = wdata;
        req.be    = be;
        enable    = 1'b1;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!ready && n < 50);
        if (!ready) begin
            $display("bus command to 0x%08h never got ready", addr);
            local_errors++;
        end
        last_rdata = rdata;
        @(posedge clk);
        #2 enable = 1'b0;    // response held over one more edge
    endtask

    task automatic wait_rx_ready();
        int polls;
        polls    = 0;
        dyn_mask = '0;
        do begin
            bus_cmd(1'b0, UART_STATUS_ADDR, '0, 4'h1);
            polls++;
        end while (!last_rdata[0] && polls < 200);
        if (!last_rdata[0]) begin
            $display("receive ready never came up");
            local_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = chk_errors + local_errors - test_start;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, errs);
        test_start = chk_errors + local_errors;
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        enable       = 1'b0;
        req          = '0;
        dyn_mask     = '0;
        dyn_exp      = '0;
        pend_known   = 1'b0;
        pend_exp     = '0;
        expect_full  = 1'b0;
        local_errors = 0;
        test_start   = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(71435));
        @(posedge rst_n);

        repeat (8) begin    // divisor lanes
            div = $urandom();
            bus_cmd(1'b1, UART_BAUD_L_ADDR, div, {3'($urandom()), 1'b1});
            bus_cmd(1'b1, UART_BAUD_H_ADDR, div >> 16, 4'h1);
            bus_cmd(1'b0, UART_BAUD_L_ADDR, '0, 4'h1);
            bus_cmd(1'b0, UART_BAUD_L_ADDR, '0, 4'h3);
            bus_cmd(1'b0, UART_BAUD_H_ADDR, '0, 4'h1);
        end
        finish_test("baud divisor");

        repeat (8) begin    // 0x100 keeps the address off the map
            bus_cmd(1'($urandom()), $urandom() | 32'h100, $urandom(), 4'hF);
            bus_cmd(1'($urandom()), UART_STATUS_ADDR, $urandom(), {3'($urandom()), 1'b0});
            bus_cmd(1'b0, UART_INT_ADDR, '0, 4'h1);
        end
        finish_test("bus errors");

        bus_cmd(1'b1, UART_BAUD_L_ADDR, TEST_DIV, 4'h3);
        bus_cmd(1'b1, UART_BAUD_H_ADDR, '0, 4'h1);
        repeat (6) begin
            bus_cmd(1'b1, UART_DATA_ADDR, $urandom(), 4'h1);
            wait_rx_ready();
            bus_cmd(1'b0, UART_DATA_ADDR, '0, 4'h1);
            dyn_mask = 32'h1;
            dyn_exp  = '0;
            bus_cmd(1'b0, UART_STATUS_ADDR, '0, 4'h1);
            dyn_mask = '0;
        end
        finish_test("loopback");

        // one byte goes straight to the shifter, four fill the FIFO
        repeat (5) bus_cmd(1'b1, UART_DATA_ADDR, $urandom(), 4'h1);
        dyn_mask = 32'h2;
        dyn_exp  = 32'h2;
        bus_cmd(1'b0, UART_STATUS_ADDR, '0, 4'h1);
        dyn_mask    = '0;
        expect_full = 1'b1;
        bus_cmd(1'b1, UART_DATA_ADDR, $urandom(), 4'h1);
        expect_full = 1'b0;
        repeat (5) begin
            wait_rx_ready();
            bus_cmd(1'b0, UART_DATA_ADDR, '0, 4'h1);
        end
        finish_test("fifo full");

        repeat (12 * TEST_DIV) @(posedge clk);    // last stop bit leaves
        bus_cmd(1'b1, UART_INT_PENDING_ADDR, 32'h3, 4'h1);
        pend_known = 1'b1;
        pend_exp   = 2'b00;
        dyn_mask   = 32'h3;
        dyn_exp    = '0;
        bus_cmd(1'b0, UART_INT_PENDING_ADDR, '0, 4'h1);
        bus_cmd(1'b1, UART_INT_ADDR, 32'h3, 4'h1);
        bus_cmd(1'b1, UART_DATA_ADDR, $urandom(), 4'h1);
        pend_known = 1'b0;
        wait_rx_ready();
        repeat (2 * TEST_DIV) @(posedge clk);
        pend_known = 1'b1;
        pend_exp   = 2'b11;
        dyn_mask   = 32'h3;
        dyn_exp    = 32'h3;
        bus_cmd(1'b0, UART_INT_PENDING_ADDR, '0, 4'h1);
        bus_cmd(1'b0, UART_DATA_ADDR, '0, 4'h1);
        pend_exp = 2'b00;
        dyn_exp  = '0;
        bus_cmd(1'b1, UART_INT_PENDING_ADDR, 32'h3, 4'h1);
        bus_cmd(1'b0, UART_INT_PENDING_ADDR, '0, 4'h1);
        bus_cmd(1'b1, UART_INT_ADDR, '0, 4'h1);
        bus_cmd(1'b0, UART_INT_PENDING_ADDR, '0, 4'h1);
        pend_known = 1'b0;
        dyn_mask   = '0;
        finish_test("interrupts");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 chk_errors + local_errors);
        if (chk_errors + local_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
uart_pkg.sv
uart_tx_fifo.sv
uart_tx.sv
uart_rx.sv
uart.sv
uart_mem.sv
tb_clkgen.sv
tb_checker.sv
uart_mem_assert.sv
tb_uart.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_uart
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
